/* dv/rv_lite_tb.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_lite_params.svh"

module rv_lite_tb;
    import rv_lite_pkg::*;

    localparam int BURST_START = 14; // rows from here on go out back to back
    localparam int WAIT_LIMIT  = 200;

    logic         clk = 1'b0;
    logic         rst_n;
    logic         instr_valid;
    logic [31:0]  instr;
    logic [31:0]  instr_pc;
    logic         credit_return;
    logic         retire_valid;
    retire_kind_e retire_kind;
    logic [4:0]   retire_rd;
    logic [31:0]  retire_wdata;
    logic         retire_regwrite;
    logic [31:0]  retire_addr;
    logic [31:0]  retire_store_data;
    logic         retire_taken;
    logic [31:0]  retire_target;

    // expected-value table
    logic [31:0]  t_word[$];
    logic [31:0]  t_pc[$];
    retire_kind_e t_kind[$];
    logic [4:0]   t_rd[$];
    logic [31:0]  t_wdata[$];
    logic         t_rw[$];
    logic [31:0]  t_addr[$];
    logic [31:0]  t_sdata[$];
    logic         t_taken[$];
    logic [31:0]  t_target[$];

    int credits;
    int returns;

    rv_lite_top UUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .instr_valid       (instr_valid),
        .instr             (instr),
        .instr_pc          (instr_pc),
        .credit_return     (credit_return),
        .retire_valid      (retire_valid),
        .retire_kind       (retire_kind),
        .retire_rd         (retire_rd),
        .retire_wdata      (retire_wdata),
        .retire_regwrite   (retire_regwrite),
        .retire_addr       (retire_addr),
        .retire_store_data (retire_store_data),
        .retire_taken      (retire_taken),
        .retire_target     (retire_target)
    );

    always #50 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_kind(input retire_kind_e got, input retire_kind_e exp,
                              input string what);
        if (got !== exp)
            stop_with_error($sformatf("CHECK FAILED at %0t ns: %s is %s, expected %s",
                                      $time, what, got.name(), exp.name()));
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
        if (got !== exp)
            stop_with_error($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                                      $time, what, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            stop_with_error($sformatf("CHECK FAILED at %0t ns: %s is %b, expected %b",
                                      $time, what, got, exp));
    endtask

    // RV32I encoders
    function automatic logic [31:0] rtype_word(input logic [6:0] f7, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] lw_word(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] sw_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] beq_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                             input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    task automatic add_row(input logic [31:0] word, input retire_kind_e kind,
                           input logic [4:0] rd, input logic [31:0] wdata, input logic rw,
                           input logic [31:0] addr, input logic [31:0] sdata,
                           input logic taken, input logic [31:0] target);
        t_pc.push_back(32'h100 + 32'(4 * t_word.size()));
        t_word.push_back(word);
        t_kind.push_back(kind);
        t_rd.push_back(rd);
        t_wdata.push_back(wdata);
        t_rw.push_back(rw);
        t_addr.push_back(addr);
        t_sdata.push_back(sdata);
        t_taken.push_back(taken);
        t_target.push_back(target);
    endtask

    task automatic alu_row(input logic [31:0] word, input logic [4:0] rd,
                           input logic [31:0] wdata);
        add_row(word, KIND_ALU, rd, wdata, rd != 5'd0, '0, '0, 1'b0, '0);
    endtask

    task automatic build_table();
        alu_row(addi_word(5'd1, 5'd0, 12'd5), 5'd1, 32'd5);
        alu_row(addi_word(5'd2, 5'd0, 12'd12), 5'd2, 32'd12);
        alu_row(rtype_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 5'd3, 32'd17);  // add
        alu_row(rtype_word(7'h20, 3'b000, 5'd4, 5'd2, 5'd1), 5'd4, 32'd7);   // sub
        alu_row(rtype_word(7'h00, 3'b100, 5'd5, 5'd1, 5'd2), 5'd5, 32'd9);   // xor
        alu_row(addi_word(5'd6, 5'd0, 12'hfc0), 5'd6, 32'hffffffc0);         // -64
        alu_row(rtype_word(7'h00, 3'b101, 5'd7, 5'd6, 5'd1), 5'd7, 32'h07fffffe);
        alu_row(addi_word(5'd0, 5'd1, 12'd100), 5'd0, 32'd105);               // x0 dropped
        alu_row(rtype_word(7'h00, 3'b000, 5'd8, 5'd0, 5'd1), 5'd8, 32'd5);
        add_row(sw_word(5'd3, 5'd2, 12'd8), KIND_STORE, '0, '0, 1'b0,
                32'd20, 32'd17, 1'b0, '0);
        add_row(lw_word(5'd9, 5'd0, 12'd20), KIND_LOAD, 5'd9, 32'd17, 1'b1,
                32'd20, '0, 1'b0, '0);
        add_row(lw_word(5'd10, 5'd0, 12'd40), KIND_LOAD, 5'd10, 32'd0, 1'b1,
                32'd40, '0, 1'b0, '0);                                          // never written
        add_row(beq_word(5'd1, 5'd8, 13'd16), KIND_BRANCH, '0, '0, 1'b0,
                '0, '0, 1'b1, 32'h140);
        add_row(beq_word(5'd1, 5'd2, 13'h1ff8), KIND_BRANCH, '0, '0, 1'b0,
                '0, '0, 1'b0, 32'h12c);                                         // offset -8
        alu_row(addi_word(5'd11, 5'd0, 12'd1), 5'd11, 32'd1);
        alu_row(rtype_word(7'h00, 3'b000, 5'd11, 5'd11, 5'd11), 5'd11, 32'd2);
        alu_row(rtype_word(7'h00, 3'b000, 5'd11, 5'd11, 5'd11), 5'd11, 32'd4);
        alu_row(addi_word(5'd12, 5'd11, 12'd3), 5'd12, 32'd7);
        alu_row(rtype_word(7'h20, 3'b000, 5'd13, 5'd12, 5'd11), 5'd13, 32'd3);
        add_row(rtype_word(7'h01, 3'b000, 5'd1, 5'd1, 5'd2), KIND_ILLEGAL, '0, '0, 1'b0,
                '0, '0, 1'b0, '0);                                              // mul
        add_row(32'h0000017f, KIND_ILLEGAL, '0, '0, 1'b0, '0, '0, 1'b0, '0);
        alu_row(rtype_word(7'h00, 3'b000, 5'd14, 5'd1, 5'd2), 5'd14, 32'd17);
        add_row(sw_word(5'd14, 5'd0, 12'd0), KIND_STORE, '0, '0, 1'b0,
                32'd0, 32'd17, 1'b0, '0);
        add_row(lw_word(5'd15, 5'd0, 12'd0), KIND_LOAD, 5'd15, 32'd17, 1'b1,
                32'd0, '0, 1'b0, '0);
        alu_row(addi_word(5'd16, 5'd15, 12'hfff), 5'd16, 32'd16);
        alu_row(rtype_word(7'h00, 3'b100, 5'd17, 5'd16, 5'd14), 5'd17, 32'd1);
        alu_row(rtype_word(7'h00, 3'b101, 5'd18, 5'd14, 5'd17), 5'd18, 32'd8);
    endtask

    // credits come back one per pulse
    always @(negedge clk) begin
        if (rst_n === 1'b1 && credit_return === 1'b1) begin
            credits++;
            returns++;
            if (credits > `RV_CREDITS)
                stop_with_error("more credits returned than were spent");
        end
    end

    task automatic send(input logic [31:0] word, input logic [31:0] pc);
        int tries;
        tries = 0;
        while (credits == 0) begin
            if (tries == WAIT_LIMIT)
                stop_with_error("driver timed out waiting for a credit");
            @(posedge clk);
            #1;
            tries++;
        end
        instr_valid = 1'b1;
        instr       = word;
        instr_pc    = pc;
        credits--;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic drive_all();
        int gap;
        for (int i = 0; i < t_word.size(); i++) begin
            gap = (i < BURST_START) ? int'($urandom % 4) : 0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            send(t_word[i], t_pc[i]);
        end
    endtask

    task automatic collect_all();
        int tries;
        string tag;
        for (int i = 0; i < t_word.size(); i++) begin
            tries = 0;
            do begin
                @(negedge clk);
                tries++;
                if (tries > WAIT_LIMIT)
                    stop_with_error($sformatf("no retire record for row %0d in time", i));
            end while (retire_valid !== 1'b1);
            tag = $sformatf("row %0d", i);
            check_kind(retire_kind, t_kind[i], {tag, " kind"});
            check_flag(retire_regwrite, t_rw[i], {tag, " regwrite"});
            if (t_kind[i] == KIND_ALU || t_kind[i] == KIND_LOAD) begin
                check_word(32'(retire_rd), 32'(t_rd[i]), {tag, " rd"});
                check_word(retire_wdata, t_wdata[i], {tag, " wdata"});
            end
            check_word(retire_addr, t_addr[i], {tag, " addr"});
            check_word(retire_store_data, t_sdata[i], {tag, " store data"});
            check_flag(retire_taken, t_taken[i], {tag, " taken"});
            check_word(retire_target, t_target[i], {tag, " target"});
        end
    endtask

    initial begin
        void'($urandom(32'h26e9));
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        instr_pc    = '0;
        credits     = `RV_CREDITS;
        returns     = 0;
        build_table();
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fork
            drive_all();
            collect_all();
        join
        check_word(32'(credits), 32'(`RV_CREDITS), "final credit count");
        check_word(32'(returns), 32'(t_word.size()), "credit_return pulses");
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/rv_lite_decode.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_lite_params.svh"

module rv_lite_decode (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         instr_valid,
    input  wire  [31:0] instr,
    input  wire  [31:0] instr_pc,
    input  wire  [31:0] rs1_data,
    input  wire  [31:0] rs2_data,
    input  wire         wb_en,
    input  wire  [4:0]  wb_rd,
    output logic        credit_return,
    output logic [4:0]  rs1_addr,
    output logic [4:0]  rs2_addr,
    output logic        dec_valid,
    output rv_lite_pkg::retire_kind_e dec_kind,
    output rv_lite_pkg::alu_op_e      dec_alu_op,
    output logic        dec_alusrc,
    output logic [31:0] dec_a,
    output logic [31:0] dec_b,
    output logic [31:0] dec_imm,
    output logic [4:0]  dec_rd,
    output logic        dec_regwrite,
    output logic        dec_memread,
    output logic        dec_memwrite,
    output logic        dec_branch,
    output logic [31:0] dec_pc
);
    import rv_lite_pkg::*;

    localparam int PW = $clog2(`RV_CREDITS);

    logic [31:0]   buf_word [`RV_CREDITS];
    logic [31:0]   buf_pc   [`RV_CREDITS];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;
    rv_instr_u     head;
    logic [1:0]    sb_cnt [`RV_NREGS]; // writes in flight per register
    logic          issue;
    retire_kind_e  kind_c;
    alu_op_e       alu_op_c;
    logic          alusrc_c;
    logic          regwrite_c;
    logic          memread_c;
    logic          memwrite_c;
    logic          branch_c;
    logic [31:0]   imm_c;

    // busy unless the last pending write is being presented now
    function automatic logic pending(input logic [4:0] a);
        return (a != '0) && (sb_cnt[a] != '0) &&
               !(sb_cnt[a] == 2'd1 && wb_en && wb_rd == a);
    endfunction

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            buf_word[wr_ptr] <= instr;
            buf_pc[wr_ptr]   <= instr_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (instr_valid)
                wr_ptr <= (wr_ptr == PW'(`RV_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            if (issue)
                rd_ptr <= (rd_ptr == PW'(`RV_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + instr_valid - issue; // credits keep this in range
        end
    end

    assign head     = buf_word[rd_ptr];
    assign rs1_addr = head.r.rs1;
    assign rs2_addr = head.r.rs2;

    always_comb begin
        issue = (count != '0) && !pending(rs1_addr) && !pending(rs2_addr);
    end

    always_comb begin
        kind_c     = KIND_ILLEGAL;
        alu_op_c   = ALU_ADD;
        alusrc_c   = 1'b0;
        regwrite_c = 1'b0;
        memread_c  = 1'b0;
        memwrite_c = 1'b0;
        branch_c   = 1'b0;
        imm_c      = '0;
        case (head.r.opcode)
            OPC_LOAD: if (head.i.funct3 == 3'b010) begin // lw
                kind_c     = KIND_LOAD;
                alusrc_c   = 1'b1;
                memread_c  = 1'b1;
                regwrite_c = 1'b1;
                imm_c      = {{20{head.i.imm12[11]}}, head.i.imm12};
            end
            OPC_OP_IMM: if (head.i.funct3 == 3'b000) begin // addi
                kind_c     = KIND_ALU;
                alusrc_c   = 1'b1;
                regwrite_c = 1'b1;
                imm_c      = {{20{head.i.imm12[11]}}, head.i.imm12};
            end
            OPC_STORE: if (head.s.funct3 == 3'b010) begin // sw
                kind_c     = KIND_STORE;
                alusrc_c   = 1'b1;
                memwrite_c = 1'b1;
                imm_c      = {{20{head.s.imm_hi[6]}}, head.s.imm_hi, head.s.imm_lo};
            end
            OPC_OP: begin
                if (head.r.funct3 == 3'b000 && head.r.funct7 == 7'b0000000) begin
                    kind_c = KIND_ALU; // add
                end else if (head.r.funct3 == 3'b000 && head.r.funct7 == 7'b0100000) begin
                    kind_c   = KIND_ALU; // sub
                    alu_op_c = ALU_SUB;
                end else if (head.r.funct3 == 3'b100 && head.r.funct7 == 7'b0000000) begin
                    kind_c   = KIND_ALU;
                    alu_op_c = ALU_XOR;
                end else if (head.r.funct3 == 3'b101 && head.r.funct7 == 7'b0000000) begin
                    kind_c   = KIND_ALU;
                    alu_op_c = ALU_SRL;
                end
                regwrite_c = (kind_c == KIND_ALU);
            end
            OPC_BRANCH: if (head.b.funct3 == 3'b000) begin // beq
                kind_c   = KIND_BRANCH;
                alu_op_c = ALU_SUB;
                branch_c = 1'b1;
                imm_c    = {{19{head.b.imm12}}, head.b.imm12, head.b.imm11,
                            head.b.imm10_5, head.b.imm4_1, 1'b0};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < `RV_NREGS; k++) begin
            if (!rst_n)
                sb_cnt[k] <= '0;
            else
                sb_cnt[k] <= sb_cnt[k]
                             + 2'(issue && regwrite_c && head.r.rd != '0 && head.r.rd == k)
                             - 2'(wb_en && wb_rd == k);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid     <= 1'b0;
            credit_return <= 1'b0;
        end else begin
            dec_valid     <= issue;
            credit_return <= issue; // slot freed
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            dec_kind     <= kind_c;
            dec_alu_op   <= alu_op_c;
            dec_alusrc   <= alusrc_c;
            dec_a        <= rs1_data;
            dec_b        <= rs2_data;
            dec_imm      <= imm_c;
            dec_rd       <= head.r.rd;
            dec_regwrite <= regwrite_c;
            dec_memread  <= memread_c;
            dec_memwrite <= memwrite_c;
            dec_branch   <= branch_c;
            dec_pc       <= buf_pc[rd_ptr];
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_lite_execute.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_lite_execute (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         dec_valid,
    input  wire rv_lite_pkg::retire_kind_e dec_kind,
    input  wire rv_lite_pkg::alu_op_e      dec_alu_op,
    input  wire         dec_alusrc,
    input  wire  [31:0] dec_a,
    input  wire  [31:0] dec_b,
    input  wire  [31:0] dec_imm,
    input  wire  [4:0]  dec_rd,
    input  wire         dec_regwrite,
    input  wire         dec_memread,
    input  wire         dec_memwrite,
    input  wire         dec_branch,
    input  wire  [31:0] dec_pc,
    output logic        ex_valid,
    output rv_lite_pkg::retire_kind_e ex_kind,
    output logic [31:0] ex_result,
    output logic [31:0] ex_store_data,
    output logic [4:0]  ex_rd,
    output logic        ex_regwrite,
    output logic        ex_memread,
    output logic        ex_memwrite,
    output logic        ex_taken,
    output logic [31:0] ex_target
);
    import rv_lite_pkg::*;

    logic [31:0] op_b;
    logic [31:0] alu_y;

    assign op_b = dec_alusrc ? dec_imm : dec_b;

    always_comb begin
        case (dec_alu_op)
            ALU_ADD: alu_y = dec_a + op_b;
            ALU_SUB: alu_y = dec_a - op_b;
            ALU_XOR: alu_y = dec_a ^ op_b;
            ALU_SRL: alu_y = dec_a >> op_b[4:0]; // shamt is low five bits
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            ex_valid <= 1'b0;
        else
            ex_valid <= dec_valid;
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_kind       <= dec_kind;
            ex_result     <= alu_y;
            ex_store_data <= dec_b;
            ex_rd         <= dec_rd;
            ex_regwrite   <= dec_regwrite;
            ex_memread    <= dec_memread;
            ex_memwrite   <= dec_memwrite;
            ex_taken      <= dec_branch && (alu_y == '0); // equal operands
            ex_target     <= dec_pc + dec_imm;
        end
    end

endmodule

`default_nettype wire

/* hdl/rv_lite_params.svh */
`ifndef RV_LITE_PARAMS_SVH
`define RV_LITE_PARAMS_SVH

// decode input buffer depth, equal to the credits the sequencer starts with
`define RV_CREDITS 4

// architectural registers
`define RV_NREGS 32

// 32-bit data memory words, indexed by the address bits above the byte offset
`define RV_DMEM_WORDS 16

`endif

/* hdl/rv_lite_pkg.sv */
`default_nettype none

package rv_lite_pkg;

    // RV32I major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011
    } rv_opcode_e;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_SRL
    } alu_op_e;

    typedef enum logic [2:0] {
        KIND_LOAD,
        KIND_ALU,
        KIND_STORE,
        KIND_BRANCH,
        KIND_ILLEGAL
    } retire_kind_e;

    // one instruction word, four field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
    } rv_instr_u;

endpackage

`default_nettype wire

/* hdl/rv_lite_regfile.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_lite_params.svh"

module rv_lite_regfile (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [4:0]  rs1_addr,
    input  wire  [4:0]  rs2_addr,
    input  wire         wb_en,
    input  wire  [4:0]  wb_rd,
    input  wire  [31:0] wb_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    logic [31:0] regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < `RV_NREGS; k++)
                regs[k] <= '0;
        end else if (wb_en && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // pending writeback is visible in the cycle it is presented
    assign rs1_data = (rs1_addr == '0) ? '0 :
                      (wb_en && wb_rd == rs1_addr) ? wb_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 :
                      (wb_en && wb_rd == rs2_addr) ? wb_data : regs[rs2_addr];

endmodule

`default_nettype wire

/* hdl/rv_lite_result.sv */
`default_nettype none
`timescale 1ns/1ps
`include "rv_lite_params.svh"

module rv_lite_result (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         ex_valid,
    input  wire rv_lite_pkg::retire_kind_e ex_kind,
    input  wire  [31:0] ex_result,
    input  wire  [31:0] ex_store_data,
    input  wire  [4:0]  ex_rd,
    input  wire         ex_regwrite,
    input  wire         ex_memread,
    input  wire         ex_memwrite,
    input  wire         ex_taken,
    input  wire  [31:0] ex_target,
    output logic        wb_en,
    output logic [4:0]  wb_rd,
    output logic [31:0] wb_data,
    output logic        retire_valid,
    output rv_lite_pkg::retire_kind_e retire_kind,
    output logic [4:0]  retire_rd,
    output logic [31:0] retire_wdata,
    output logic        retire_regwrite,
    output logic [31:0] retire_addr,
    output logic [31:0] retire_store_data,
    output logic        retire_taken,
    output logic [31:0] retire_target
);
    import rv_lite_pkg::*;

    localparam int AW = $clog2(`RV_DMEM_WORDS);

    logic [31:0]   dmem [`RV_DMEM_WORDS];
    logic [AW-1:0] widx;

    assign widx = ex_result[2 +: AW]; // word index above byte offset

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int k = 0; k < `RV_DMEM_WORDS; k++)
                dmem[k] <= '0;
        end else if (ex_valid && ex_memwrite) begin
            dmem[widx] <= ex_store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            wb_en        <= 1'b0;
        end else begin
            retire_valid <= ex_valid;
            wb_en        <= ex_valid && ex_regwrite && ex_rd != '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            wb_rd             <= ex_rd;
            wb_data           <= ex_memread ? dmem[widx] : ex_result;
            retire_kind       <= ex_kind;
            retire_addr       <= (ex_memread || ex_memwrite) ? ex_result : '0;
            retire_store_data <= ex_memwrite ? ex_store_data : '0;
            retire_taken      <= ex_taken;
            retire_target     <= (ex_kind == KIND_BRANCH) ? ex_target : '0;
        end
    end

    assign retire_rd       = wb_rd;
    assign retire_wdata    = wb_data;
    assign retire_regwrite = wb_en;

endmodule

`default_nettype wire

/* hdl/rv_lite_top.sv */
`default_nettype none
`timescale 1ns/1ps

module rv_lite_top (
    input  wire         clk,
    input  wire         rst_n,
    input  wire         instr_valid,
    input  wire  [31:0] instr,
    input  wire  [31:0] instr_pc,
    output logic        credit_return,
    output logic        retire_valid,
    output rv_lite_pkg::retire_kind_e retire_kind,
    output logic [4:0]  retire_rd,
    output logic [31:0] retire_wdata,
    output logic        retire_regwrite,
    output logic [31:0] retire_addr,
    output logic [31:0] retire_store_data,
    output logic        retire_taken,
    output logic [31:0] retire_target
);
    import rv_lite_pkg::*;

    logic [4:0]   rs1_addr;
    logic [4:0]   rs2_addr;
    logic [31:0]  rs1_data;
    logic [31:0]  rs2_data;
    logic         wb_en;
    logic [4:0]   wb_rd;
    logic [31:0]  wb_data;

    logic         dec_valid;
    retire_kind_e dec_kind;
    alu_op_e      dec_alu_op;
    logic         dec_alusrc;
    logic [31:0]  dec_a;
    logic [31:0]  dec_b;
    logic [31:0]  dec_imm;
    logic [4:0]   dec_rd;
    logic         dec_regwrite;
    logic         dec_memread;
    logic         dec_memwrite;
    logic         dec_branch;
    logic [31:0]  dec_pc;

    logic         ex_valid;
    retire_kind_e ex_kind;
    logic [31:0]  ex_result;
    logic [31:0]  ex_store_data;
    logic [4:0]   ex_rd;
    logic         ex_regwrite;
    logic         ex_memread;
    logic         ex_memwrite;
    logic         ex_taken;
    logic [31:0]  ex_target;

    rv_lite_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .wb_en         (wb_en),
        .wb_rd         (wb_rd),
        .credit_return (credit_return),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .dec_valid     (dec_valid),
        .dec_kind      (dec_kind),
        .dec_alu_op    (dec_alu_op),
        .dec_alusrc    (dec_alusrc),
        .dec_a         (dec_a),
        .dec_b         (dec_b),
        .dec_imm       (dec_imm),
        .dec_rd        (dec_rd),
        .dec_regwrite  (dec_regwrite),
        .dec_memread   (dec_memread),
        .dec_memwrite  (dec_memwrite),
        .dec_branch    (dec_branch),
        .dec_pc        (dec_pc)
    );

    rv_lite_regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb_en    (wb_en),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    rv_lite_execute u_execute (
        .clk           (clk),
        .rst_n         (rst_n),
        .dec_valid     (dec_valid),
        .dec_kind      (dec_kind),
        .dec_alu_op    (dec_alu_op),
        .dec_alusrc    (dec_alusrc),
        .dec_a         (dec_a),
        .dec_b         (dec_b),
        .dec_imm       (dec_imm),
        .dec_rd        (dec_rd),
        .dec_regwrite  (dec_regwrite),
        .dec_memread   (dec_memread),
        .dec_memwrite  (dec_memwrite),
        .dec_branch    (dec_branch),
        .dec_pc        (dec_pc),
        .ex_valid      (ex_valid),
        .ex_kind       (ex_kind),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .ex_rd         (ex_rd),
        .ex_regwrite   (ex_regwrite),
        .ex_memread    (ex_memread),
        .ex_memwrite   (ex_memwrite),
        .ex_taken      (ex_taken),
        .ex_target     (ex_target)
    );

    rv_lite_result u_result (
        .clk               (clk),
        .rst_n             (rst_n),
        .ex_valid          (ex_valid),
        .ex_kind           (ex_kind),
        .ex_result         (ex_result),
        .ex_store_data     (ex_store_data),
        .ex_rd             (ex_rd),
        .ex_regwrite       (ex_regwrite),
        .ex_memread        (ex_memread),
        .ex_memwrite       (ex_memwrite),
        .ex_taken          (ex_taken),
        .ex_target         (ex_target),
        .wb_en             (wb_en),
        .wb_rd             (wb_rd),
        .wb_data           (wb_data),
        .retire_valid      (retire_valid),
        .retire_kind       (retire_kind),
        .retire_rd         (retire_rd),
        .retire_wdata      (retire_wdata),
        .retire_regwrite   (retire_regwrite),
        .retire_addr       (retire_addr),
        .retire_store_data (retire_store_data),
        .retire_taken      (retire_taken),
        .retire_target     (retire_target)
    );

endmodule

`default_nettype wire

/* rv_lite_core.f */
+incdir+hdl
hdl/rv_lite_pkg.sv
hdl/rv_lite_regfile.sv
hdl/rv_lite_decode.sv
hdl/rv_lite_execute.sv
hdl/rv_lite_result.sv
hdl/rv_lite_top.sv
dv/rv_lite_tb.sv
